// File: controlBlock_params.svh
`ifndef CONTROLBLOCK_PARAMS_SVH
`define CONTROLBLOCK_PARAMS_SVH

// instruction word and its fields
`define INSTR_W 16
`define OPCODE_W 5
`define FUNC_W 2
`define REG_W 3

// alu control widths
`define ALUOP_W 4
// shared by aluSrc and regWrtSrc
`define SRC_W 3

// branch condition select
`define BR_W 3

`endif

// File: isaPkg.sv
`default_nettype none

`include "controlBlock_params.svh"

package isaPkg;

    // opcode encodings of the teaching isa
    typedef enum logic [`OPCODE_W-1:0] {
        OP_HALT = 5'b00000, OP_NOP = 5'b00001, OP_SIIC = 5'b00010, OP_RTI = 5'b00011,
        OP_J = 5'b00100, OP_JR = 5'b00101, OP_JAL = 5'b00110, OP_JALR = 5'b00111,
        OP_ADDI = 5'b01000, OP_SUBI = 5'b01001, OP_XORI = 5'b01010, OP_ANDNI = 5'b01011,
        OP_BEQZ = 5'b01100, OP_BNEZ = 5'b01101, OP_BLTZ = 5'b01110, OP_BGEZ = 5'b01111,
        OP_ST = 5'b10000, OP_LD = 5'b10001, OP_SLBI = 5'b10010, OP_STU = 5'b10011,
        OP_ROLI = 5'b10100, OP_SLLI = 5'b10101, OP_RORI = 5'b10110, OP_SRLI = 5'b10111,
        OP_LBI = 5'b11000, OP_BTR = 5'b11001, OP_ALU_OP2 = 5'b11010, OP_ALU_OP1 = 5'b11011,
        OP_SEQ = 5'b11100, OP_SLT = 5'b11101, OP_SLE = 5'b11110, OP_SCO = 5'b11111
    } opCodeT;

    // func codes under ALU_OP1
    localparam logic [`FUNC_W-1:0] FUNC_ADD = 2'h0;
    localparam logic [`FUNC_W-1:0] FUNC_SUB = 2'h1;
    localparam logic [`FUNC_W-1:0] FUNC_XOR = 2'h2;
    localparam logic [`FUNC_W-1:0] FUNC_ANDN = 2'h3;

    // func codes under ALU_OP2
    localparam logic [`FUNC_W-1:0] FUNC_ROL = 2'h0;
    localparam logic [`FUNC_W-1:0] FUNC_SLL = 2'h1;
    localparam logic [`FUNC_W-1:0] FUNC_ROR = 2'h2;
    localparam logic [`FUNC_W-1:0] FUNC_SRL = 2'h3;

    // one member per decoded instruction
    typedef enum logic [5:0] {
        KIND_BTR, KIND_ADD, KIND_SUB, KIND_XOR, KIND_ANDN,
        KIND_ROL, KIND_SLL, KIND_ROR, KIND_SRL,
        KIND_SEQ, KIND_SLT, KIND_SLE, KIND_SCO,
        KIND_ADDI, KIND_SUBI, KIND_XORI, KIND_ANDNI,
        KIND_ROLI, KIND_SLLI, KIND_RORI, KIND_SRLI,
        KIND_ST, KIND_LD, KIND_STU,
        KIND_LBI, KIND_SLBI, KIND_JR, KIND_JALR,
        KIND_BEQZ, KIND_BNEZ, KIND_BLTZ, KIND_BGEZ,
        KIND_J, KIND_JAL, KIND_HALT, KIND_NOP,
        KIND_ILLEGAL
    } instrKindT;

    typedef struct packed {
        opCodeT opCode;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] rd;
        logic [`FUNC_W-1:0] func;
    } rViewT;

    // imm5 takes what is left after opcode and two register fields
    typedef struct packed {
        opCodeT opCode;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rd;
        logic [`INSTR_W-`OPCODE_W-2*`REG_W-1:0] imm5;
    } iViewT;

    typedef union packed {
        rViewT rView;
        iViewT iView;
    } instrWordT;

endpackage

`default_nettype wire

// File: ctrlPkg.sv
`default_nettype none

`include "controlBlock_params.svh"

package ctrlPkg;

    // alu operation codes
    localparam logic [`ALUOP_W-1:0] ALUOP_ROL = 4'd0;
    localparam logic [`ALUOP_W-1:0] ALUOP_SLL = 4'd1;
    localparam logic [`ALUOP_W-1:0] ALUOP_SRL = 4'd3;
    localparam logic [`ALUOP_W-1:0] ALUOP_ADD = 4'd4;
    localparam logic [`ALUOP_W-1:0] ALUOP_XOR = 4'd6;
    localparam logic [`ALUOP_W-1:0] ALUOP_ANDN = 4'd7;
    localparam logic [`ALUOP_W-1:0] ALUOP_ROR = 4'd8;

    // alu b-operand source
    localparam logic [`SRC_W-1:0] ALUSRC_IMM_SEXT = 3'd0;
    localparam logic [`SRC_W-1:0] ALUSRC_IMM_ZEXT = 3'd1;
    localparam logic [`SRC_W-1:0] ALUSRC_RT = 3'd4;
    localparam logic [`SRC_W-1:0] ALUSRC_ZERO = 3'd5;

    // destination register select
    localparam logic [1:0] DST_I_RD = 2'd0;
    localparam logic [1:0] DST_RS = 2'd1;
    localparam logic [1:0] DST_R_RD = 2'd2;
    localparam logic [1:0] DST_LINK = 2'd3;

    // register write data source
    localparam logic [`SRC_W-1:0] WSRC_MEM = 3'd0;
    localparam logic [`SRC_W-1:0] WSRC_ALU = 3'd1;
    localparam logic [`SRC_W-1:0] WSRC_PC = 3'd2;
    localparam logic [`SRC_W-1:0] WSRC_SET = 3'd3;
    localparam logic [`SRC_W-1:0] WSRC_LBI = 3'd4;
    localparam logic [`SRC_W-1:0] WSRC_SLBI = 3'd5;
    localparam logic [`SRC_W-1:0] WSRC_BTR = 3'd6;

    typedef enum logic [`BR_W-1:0] {
        NOBR = 3'd0,
        EQZ = 3'd1,
        NEZ = 3'd2,
        LTZ = 3'd3,
        GEQZ = 3'd4
    } brTypeT;

    typedef struct packed {
        logic [`ALUOP_W-1:0] aluOp;
        logic [`SRC_W-1:0] aluSrc;
        logic invA;
        logic invB;
        logic cin;
        logic sign;
    } aluCtrlT;

    typedef struct packed {
        logic regWrt;
        logic [1:0] regDst;
        logic [`SRC_W-1:0] regWrtSrc;
        logic memWrt;
        logic memEn;
    } writeCtrlT;

    typedef struct packed {
        logic jump;
        logic ret;
        logic pcOffSel;
        brTypeT brType;
    } flowCtrlT;

endpackage

`default_nettype wire

// File: instrClassify.sv
`timescale 1ns/1ps
`default_nettype none

module instrClassify (
    input  isaPkg::instrWordT instr,
    output isaPkg::instrKindT instrKind,
    output logic halt,
    output logic err
);
    import isaPkg::*;

    always_comb begin
        instrKind = KIND_ILLEGAL;
        case (instr.iView.opCode)
            // func only matters for the two r-format alu groups
            OP_BTR: instrKind = KIND_BTR;
            OP_ALU_OP1: begin
                case (instr.rView.func)
                    FUNC_ADD: instrKind = KIND_ADD;
                    FUNC_SUB: instrKind = KIND_SUB;
                    FUNC_XOR: instrKind = KIND_XOR;
                    FUNC_ANDN: instrKind = KIND_ANDN;
                endcase
            end
            OP_ALU_OP2: begin
                case (instr.rView.func)
                    FUNC_ROL: instrKind = KIND_ROL;
                    FUNC_SLL: instrKind = KIND_SLL;
                    FUNC_ROR: instrKind = KIND_ROR;
                    FUNC_SRL: instrKind = KIND_SRL;
                endcase
            end
            OP_SEQ: instrKind = KIND_SEQ;
            OP_SLT: instrKind = KIND_SLT;
            OP_SLE: instrKind = KIND_SLE;
            OP_SCO: instrKind = KIND_SCO;

            // i1
            OP_ADDI: instrKind = KIND_ADDI;
            OP_SUBI: instrKind = KIND_SUBI;
            OP_XORI: instrKind = KIND_XORI;
            OP_ANDNI: instrKind = KIND_ANDNI;
            OP_ROLI: instrKind = KIND_ROLI;
            OP_SLLI: instrKind = KIND_SLLI;
            OP_RORI: instrKind = KIND_RORI;
            OP_SRLI: instrKind = KIND_SRLI;
            OP_ST: instrKind = KIND_ST;
            OP_LD: instrKind = KIND_LD;
            OP_STU: instrKind = KIND_STU;

            // i2
            OP_LBI: instrKind = KIND_LBI;
            OP_SLBI: instrKind = KIND_SLBI;
            OP_JR: instrKind = KIND_JR;
            OP_JALR: instrKind = KIND_JALR;
            OP_BEQZ: instrKind = KIND_BEQZ;
            OP_BNEZ: instrKind = KIND_BNEZ;
            OP_BLTZ: instrKind = KIND_BLTZ;
            OP_BGEZ: instrKind = KIND_BGEZ;

            // j
            OP_J: instrKind = KIND_J;
            OP_JAL: instrKind = KIND_JAL;

            OP_HALT: instrKind = KIND_HALT;
            OP_NOP: instrKind = KIND_NOP;

            // SIIC and RTI are not supported
            default: instrKind = KIND_ILLEGAL;
        endcase
    end

    assign halt = (instrKind == KIND_HALT);
    assign err = (instrKind == KIND_ILLEGAL);

endmodule

`default_nettype wire

// File: aluCtrlDecode.sv
`timescale 1ns/1ps
`default_nettype none

module aluCtrlDecode (
    input  isaPkg::instrKindT instrKind,
    output ctrlPkg::aluCtrlT aluCtrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        // add on rt unless told otherwise
        case (instrKind)
            KIND_ROL, KIND_ROLI: aluCtrl.aluOp = ALUOP_ROL;
            KIND_SLL, KIND_SLLI: aluCtrl.aluOp = ALUOP_SLL;
            KIND_SRL, KIND_SRLI: aluCtrl.aluOp = ALUOP_SRL;
            KIND_XOR, KIND_XORI: aluCtrl.aluOp = ALUOP_XOR;
            KIND_ANDN, KIND_ANDNI: aluCtrl.aluOp = ALUOP_ANDN;
            KIND_ROR, KIND_RORI: aluCtrl.aluOp = ALUOP_ROR;
            default: aluCtrl.aluOp = ALUOP_ADD;
        endcase

        case (instrKind)
            // arithmetic and address immediates are sign extended
            KIND_ADDI, KIND_SUBI, KIND_ST, KIND_LD, KIND_STU:
                aluCtrl.aluSrc = ALUSRC_IMM_SEXT;
            KIND_XORI, KIND_ANDNI, KIND_ROLI, KIND_SLLI, KIND_RORI, KIND_SRLI:
                aluCtrl.aluSrc = ALUSRC_IMM_ZEXT;
            // branches test rs against zero
            KIND_BEQZ, KIND_BNEZ, KIND_BLTZ, KIND_BGEZ:
                aluCtrl.aluSrc = ALUSRC_ZERO;
            default: aluCtrl.aluSrc = ALUSRC_RT;
        endcase

        // subtract as ~a + b + 1
        aluCtrl.invA = instrKind inside {KIND_SUB, KIND_SUBI};
        aluCtrl.invB = instrKind inside {KIND_ANDN, KIND_ANDNI, KIND_SEQ, KIND_SLT, KIND_SLE};
        aluCtrl.cin = instrKind inside {KIND_SUB, KIND_SUBI, KIND_SEQ, KIND_SLT, KIND_SLE};
        aluCtrl.sign = instrKind inside {KIND_ADD, KIND_SUB, KIND_SEQ, KIND_SLT, KIND_SLE,
                                         KIND_ADDI, KIND_SUBI, KIND_STU,
                                         KIND_BEQZ, KIND_BNEZ, KIND_BLTZ, KIND_BGEZ};
    end

endmodule

`default_nettype wire

// File: writeCtrlDecode.sv
`timescale 1ns/1ps
`default_nettype none

module writeCtrlDecode (
    input  isaPkg::instrKindT instrKind,
    output ctrlPkg::writeCtrlT writeCtrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        // everything else writes a register
        writeCtrl.regWrt = !(instrKind inside {KIND_ST, KIND_JR, KIND_J,
                                               KIND_BEQZ, KIND_BNEZ, KIND_BLTZ, KIND_BGEZ,
                                               KIND_HALT, KIND_NOP, KIND_ILLEGAL});

        case (instrKind)
            KIND_ADDI, KIND_SUBI, KIND_XORI, KIND_ANDNI,
            KIND_ROLI, KIND_SLLI, KIND_RORI, KIND_SRLI, KIND_LD:
                writeCtrl.regDst = DST_I_RD;
            KIND_STU, KIND_LBI, KIND_SLBI:
                writeCtrl.regDst = DST_RS;
            KIND_BTR, KIND_ADD, KIND_SUB, KIND_XOR, KIND_ANDN,
            KIND_ROL, KIND_SLL, KIND_ROR, KIND_SRL,
            KIND_SEQ, KIND_SLT, KIND_SLE, KIND_SCO:
                writeCtrl.regDst = DST_R_RD;
            // link register
            KIND_JALR, KIND_JAL:
                writeCtrl.regDst = DST_LINK;
            default: writeCtrl.regDst = 2'd0;
        endcase

        case (instrKind)
            KIND_LD: writeCtrl.regWrtSrc = WSRC_MEM;
            KIND_ADD, KIND_SUB, KIND_XOR, KIND_ANDN,
            KIND_ROL, KIND_SLL, KIND_ROR, KIND_SRL,
            KIND_ADDI, KIND_SUBI, KIND_XORI, KIND_ANDNI,
            KIND_ROLI, KIND_SLLI, KIND_RORI, KIND_SRLI, KIND_STU:
                writeCtrl.regWrtSrc = WSRC_ALU;
            KIND_JAL, KIND_JALR: writeCtrl.regWrtSrc = WSRC_PC;
            KIND_SEQ, KIND_SLT, KIND_SLE, KIND_SCO:
                writeCtrl.regWrtSrc = WSRC_SET;
            KIND_LBI: writeCtrl.regWrtSrc = WSRC_LBI;
            KIND_SLBI: writeCtrl.regWrtSrc = WSRC_SLBI;
            KIND_BTR: writeCtrl.regWrtSrc = WSRC_BTR;
            default: writeCtrl.regWrtSrc = 3'd0;
        endcase

        // STU also writes back the updated base
        writeCtrl.memEn = instrKind inside {KIND_ST, KIND_LD, KIND_STU};
        writeCtrl.memWrt = instrKind inside {KIND_ST, KIND_STU};
    end

endmodule

`default_nettype wire

// File: flowCtrlDecode.sv
`timescale 1ns/1ps
`default_nettype none

module flowCtrlDecode (
    input  isaPkg::instrKindT instrKind,
    output ctrlPkg::flowCtrlT flowCtrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        flowCtrl.jump = instrKind inside {KIND_JR, KIND_JALR, KIND_J, KIND_JAL};
        // target comes from a register
        flowCtrl.ret = instrKind inside {KIND_JR, KIND_JALR};
        // pc-relative displacement
        flowCtrl.pcOffSel = instrKind inside {KIND_J, KIND_JAL};

        case (instrKind)
            KIND_BEQZ: flowCtrl.brType = EQZ;
            KIND_BNEZ: flowCtrl.brType = NEZ;
            KIND_BLTZ: flowCtrl.brType = LTZ;
            KIND_BGEZ: flowCtrl.brType = GEQZ;
            default: flowCtrl.brType = NOBR;
        endcase
    end

endmodule

`default_nettype wire

// File: controlBlock.sv
`timescale 1ns/1ps
`default_nettype none

module controlBlock (
    input  isaPkg::instrWordT instr,
    output ctrlPkg::aluCtrlT aluCtrl,
    output ctrlPkg::writeCtrlT writeCtrl,
    output ctrlPkg::flowCtrlT flowCtrl,
    output logic halt,
    output logic err
);
    import isaPkg::*;

    instrKindT instrKind;

    // only the classifier looks at opcode and func
    instrClassify u_instrClassify (
        .instr(instr),
        .instrKind(instrKind),
        .halt(halt),
        .err(err)
    );

    aluCtrlDecode u_aluCtrlDecode (
        .instrKind(instrKind),
        .aluCtrl(aluCtrl)
    );

    writeCtrlDecode u_writeCtrlDecode (
        .instrKind(instrKind),
        .writeCtrl(writeCtrl)
    );

    flowCtrlDecode u_flowCtrlDecode (
        .instrKind(instrKind),
        .flowCtrl(flowCtrl)
    );

endmodule

`default_nettype wire

// File: tbChecker.sv
`timescale 1ns/1ps
`default_nettype none

module tbChecker (
    input  logic clk,
    input  logic rstN,
    input  logic checkEn,
    input  isaPkg::instrWordT instr,
    input  ctrlPkg::aluCtrlT aluCtrl,
    input  ctrlPkg::writeCtrlT writeCtrl,
    input  ctrlPkg::flowCtrlT flowCtrl,
    input  logic halt,
    input  logic err,
    input  ctrlPkg::aluCtrlT expAlu,
    input  ctrlPkg::writeCtrlT expWr,
    input  ctrlPkg::flowCtrlT expFlow,
    input  logic expHalt,
    input  logic expErr,
    output int errCount,
    output int checkCount
);
    int errs;
    int checks;

    assign errCount = errs;
    assign checkCount = checks;

    task automatic reportMismatch(input string field);
        errs++;
        $display("[ERROR] %0t: %s mismatch for instr %h (opcode %b)",
                 $time, field, instr, instr.rView.opCode);
    endtask

    // decoder outputs have settled half a cycle after the word changed
    always @(negedge clk) begin
        if (!rstN) begin
            errs = 0;
            checks = 0;
        end else if (checkEn) begin
            checks++;
            if (aluCtrl.aluOp !== expAlu.aluOp) reportMismatch("aluOp");
            if (aluCtrl.aluSrc !== expAlu.aluSrc) reportMismatch("aluSrc");
            if (aluCtrl.invA !== expAlu.invA) reportMismatch("invA");
            if (aluCtrl.invB !== expAlu.invB) reportMismatch("invB");
            if (aluCtrl.cin !== expAlu.cin) reportMismatch("cin");
            if (aluCtrl.sign !== expAlu.sign) reportMismatch("sign");
            if (writeCtrl.regWrt !== expWr.regWrt) reportMismatch("regWrt");
            if (writeCtrl.regDst !== expWr.regDst) reportMismatch("regDst");
            if (writeCtrl.regWrtSrc !== expWr.regWrtSrc) reportMismatch("regWrtSrc");
            if (writeCtrl.memWrt !== expWr.memWrt) reportMismatch("memWrt");
            if (writeCtrl.memEn !== expWr.memEn) reportMismatch("memEn");
            if (flowCtrl.jump !== expFlow.jump) reportMismatch("jump");
            if (flowCtrl.ret !== expFlow.ret) reportMismatch("ret");
            if (flowCtrl.pcOffSel !== expFlow.pcOffSel) reportMismatch("pcOffSel");
            if (flowCtrl.brType !== expFlow.brType) reportMismatch("brType");
            if (halt !== expHalt) reportMismatch("halt");
            if (err !== expErr) reportMismatch("err");
        end
    end

endmodule

`default_nettype wire

// File: tbControlBlock.sv
`timescale 1ns/1ps
`default_nettype none

module tbControlBlock;
    import isaPkg::*;
    import ctrlPkg::*;

    // how the low 11 bits of a word are filled
    localparam logic [1:0] IFMT = 2'd0;
    localparam logic [1:0] RFIX = 2'd1;
    localparam logic [1:0] RANY = 2'd2;

    typedef struct packed {
        opCodeT op;
        logic [1:0] func;
        logic [1:0] mode;
        aluCtrlT alu;
        writeCtrlT wr;
        flowCtrlT flow;
        logic halt;
        logic err;
    } rowT;

    logic clk;
    logic rstN;
    instrWordT instr;
    aluCtrlT aluCtrl;
    writeCtrlT writeCtrl;
    flowCtrlT flowCtrl;
    logic halt;
    logic err;

    logic checkEn;
    aluCtrlT expAlu;
    writeCtrlT expWr;
    flowCtrlT expFlow;
    logic expHalt;
    logic expErr;
    int errCount;
    int checkCount;
    int applied;

    rowT rows[$];
    logic rowsReady;
    logic [15:0] lfsr;

    controlBlock u_controlBlock (
        .instr(instr),
        .aluCtrl(aluCtrl),
        .writeCtrl(writeCtrl),
        .flowCtrl(flowCtrl),
        .halt(halt),
        .err(err)
    );

    tbChecker u_tbChecker (
        .clk(clk),
        .rstN(rstN),
        .checkEn(checkEn),
        .instr(instr),
        .aluCtrl(aluCtrl),
        .writeCtrl(writeCtrl),
        .flowCtrl(flowCtrl),
        .halt(halt),
        .err(err),
        .expAlu(expAlu),
        .expWr(expWr),
        .expFlow(expFlow),
        .expHalt(expHalt),
        .expErr(expErr),
        .errCount(errCount),
        .checkCount(checkCount)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        #1 rstN = 1'b1;
    end

    // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic takeFill(output logic [10:0] v);
        v = '0;
        for (int i = 0; i < 11; i++) begin
            v = {v[9:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic addRow(input opCodeT op, input int func, input logic [1:0] mode,
                          input int aluOp, input int aluSrc, input int aluBits,
                          input int regWrt, input int regDst, input int wrSrc,
                          input int memBits, input int flowBits, input brTypeT br,
                          input int hltErr);
        rowT r;
        r.op = op;
        r.func = func[1:0];
        r.mode = mode;
        r.alu = {aluOp[3:0], aluSrc[2:0], aluBits[3:0]};
        r.wr = {regWrt[0], regDst[1:0], wrSrc[2:0], memBits[1:0]};
        r.flow = {flowBits[2:0], br};
        r.halt = hltErr[1];
        r.err = hltErr[0];
        rows.push_back(r);
    endtask

    task automatic buildRows();
        // op, func, mode, aluOp, aluSrc, invA/invB/cin/sign, regWrt, regDst,
        // regWrtSrc, memWrt/memEn, jump/ret/pcOffSel, brType, halt/err
        addRow(OP_BTR,     0, RANY, 4, 4, 'b0000, 1, 2, 6, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ALU_OP1, 0, RFIX, 4, 4, 'b0001, 1, 2, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ALU_OP1, 1, RFIX, 4, 4, 'b1011, 1, 2, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ALU_OP1, 2, RFIX, 6, 4, 'b0000, 1, 2, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ALU_OP1, 3, RFIX, 7, 4, 'b0100, 1, 2, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ALU_OP2, 0, RFIX, 0, 4, 'b0000, 1, 2, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ALU_OP2, 1, RFIX, 1, 4, 'b0000, 1, 2, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ALU_OP2, 2, RFIX, 8, 4, 'b0000, 1, 2, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ALU_OP2, 3, RFIX, 3, 4, 'b0000, 1, 2, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_SEQ,     0, RANY, 4, 4, 'b0111, 1, 2, 3, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_SLT,     0, RANY, 4, 4, 'b0111, 1, 2, 3, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_SLE,     0, RANY, 4, 4, 'b0111, 1, 2, 3, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_SCO,     0, RANY, 4, 4, 'b0000, 1, 2, 3, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ADDI,    0, IFMT, 4, 0, 'b0001, 1, 0, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_SUBI,    0, IFMT, 4, 0, 'b1011, 1, 0, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_XORI,    0, IFMT, 6, 1, 'b0000, 1, 0, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ANDNI,   0, IFMT, 7, 1, 'b0100, 1, 0, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ROLI,    0, IFMT, 0, 1, 'b0000, 1, 0, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_SLLI,    0, IFMT, 1, 1, 'b0000, 1, 0, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_RORI,    0, IFMT, 8, 1, 'b0000, 1, 0, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_SRLI,    0, IFMT, 3, 1, 'b0000, 1, 0, 1, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_ST,      0, IFMT, 4, 0, 'b0000, 0, 0, 0, 'b11, 'b000, NOBR, 'b00);
        addRow(OP_LD,      0, IFMT, 4, 0, 'b0000, 1, 0, 0, 'b01, 'b000, NOBR, 'b00);
        addRow(OP_STU,     0, IFMT, 4, 0, 'b0001, 1, 1, 1, 'b11, 'b000, NOBR, 'b00);
        addRow(OP_LBI,     0, IFMT, 4, 4, 'b0000, 1, 1, 4, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_SLBI,    0, IFMT, 4, 4, 'b0000, 1, 1, 5, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_JR,      0, IFMT, 4, 4, 'b0000, 0, 0, 0, 'b00, 'b110, NOBR, 'b00);
        addRow(OP_JALR,    0, IFMT, 4, 4, 'b0000, 1, 3, 2, 'b00, 'b110, NOBR, 'b00);
        addRow(OP_BEQZ,    0, IFMT, 4, 5, 'b0001, 0, 0, 0, 'b00, 'b000, EQZ,  'b00);
        addRow(OP_BNEZ,    0, IFMT, 4, 5, 'b0001, 0, 0, 0, 'b00, 'b000, NEZ,  'b00);
        addRow(OP_BLTZ,    0, IFMT, 4, 5, 'b0001, 0, 0, 0, 'b00, 'b000, LTZ,  'b00);
        addRow(OP_BGEZ,    0, IFMT, 4, 5, 'b0001, 0, 0, 0, 'b00, 'b000, GEQZ, 'b00);
        addRow(OP_J,       0, IFMT, 4, 4, 'b0000, 0, 0, 0, 'b00, 'b101, NOBR, 'b00);
        addRow(OP_JAL,     0, IFMT, 4, 4, 'b0000, 1, 3, 2, 'b00, 'b101, NOBR, 'b00);
        addRow(OP_HALT,    0, IFMT, 4, 4, 'b0000, 0, 0, 0, 'b00, 'b000, NOBR, 'b10);
        addRow(OP_NOP,     0, IFMT, 4, 4, 'b0000, 0, 0, 0, 'b00, 'b000, NOBR, 'b00);
        addRow(OP_SIIC,    0, IFMT, 4, 4, 'b0000, 0, 0, 0, 'b00, 'b000, NOBR, 'b01);
        addRow(OP_RTI,     0, IFMT, 4, 4, 'b0000, 0, 0, 0, 'b00, 'b000, NOBR, 'b01);
    endtask

    task automatic applyWord(input rowT r, input logic [1:0] fn);
        logic [10:0] fill;
        @(posedge clk);
        #1;
        takeFill(fill);
        if (r.mode == IFMT) begin
            instr = {r.op, fill};
        end else begin
            instr = {r.op, fill[10:2], fn};
        end
        expAlu = r.alu;
        expWr = r.wr;
        expFlow = r.flow;
        expHalt = r.halt;
        expErr = r.err;
        checkEn = 1'b1;
        applied++;
    endtask

    initial begin
        int nFunc;
        instr = '0;
        checkEn = 1'b0;
        expAlu = '0;
        expWr = '0;
        expFlow = '0;
        expHalt = 1'b0;
        expErr = 1'b0;
        applied = 0;
        lfsr = 16'd10;
        rowsReady = 1'b0;
        buildRows();
        rowsReady = 1'b1;
        wait (rstN);
        foreach (rows[i]) begin
            nFunc = (rows[i].mode == RANY) ? 4 : 1;
            for (int f = 0; f < nFunc; f++) begin
                // twice so the register fields differ for the same opcode and func
                repeat (2) applyWord(rows[i], (rows[i].mode == RANY) ? f[1:0] : rows[i].func);
            end
        end
        @(posedge clk);
        #1 checkEn = 1'b0;
        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (checkCount != applied) begin
            $display("checker compared %0d words but %0d were applied", checkCount, applied);
        end
        if (errCount == 0 && checkCount == applied) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        wait (rowsReady);
        repeat (rows.size() * 3 + 40) @(posedge clk);
        $display("timeout: stimulus did not finish within %0d cycles", rows.size() * 3 + 40);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
instrClassify.sv
aluCtrlDecode.sv
writeCtrlDecode.sv
flowCtrlDecode.sv
controlBlock.sv
tbChecker.sv
tbControlBlock.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
verilator --binary --timing -f all.f --top-module tbControlBlock -o simControlBlock \
    > build.log 2>&1 &&
./obj_dir/simControlBlock > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "^Done: no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
